// ==== common/rename_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// shared widths, index typedefs and the request, response and retire
// structs of the two-wide rename stage
////////////////////////////////////////////////////////////////////////////
package rename_pkg;

	////////////////////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////////////////////

	parameter int arch_regs = 32;          // architectural registers
	parameter int arch_bits = 5;           // bits of an arch index
	parameter int phys_bits = 6;           // bits of a physical tag, up to 64 regs

	typedef logic [arch_bits-1:0] arch_idx_t;  // architectural register index
	typedef logic [phys_bits-1:0] phys_idx_t;  // physical register tag

	////////////////////////////////////////////////////////////////////////////
	// per-slot records
	////////////////////////////////////////////////////////////////////////////

	// one decoded instruction entering rename
	typedef struct packed {
		logic      valid;     // slot holds an instruction
		logic      has_dest;  // writes a register, needs a new tag
		arch_idx_t dest;      // arch destination
		arch_idx_t opa;       // arch source a
		arch_idx_t opb;       // arch source b
		logic      opa_imm;   // source a is an immediate, no lookup
		logic      opb_imm;   // source b is an immediate, no lookup
	} rename_req_t;

	// one renamed instruction leaving the stage
	typedef struct packed {
		logic      valid;     // renamed this cycle
		phys_idx_t dest_tag;  // new tag, zero without a dest
		phys_idx_t opa_tag;   // tag of source a, zero for immediate
		phys_idx_t opb_tag;   // tag of source b, zero for immediate
		logic      opa_imm;   // passed through
		logic      opb_imm;   // passed through
	} rename_rsp_t;

	// one retiring register write, also used for freed tags
	typedef struct packed {
		logic      valid;  // slot active
		arch_idx_t dest;   // arch register written
		phys_idx_t tag;    // committed tag, or the freed one
	} retire_t;

endpackage

// ==== hdl/rename_unit.sv ====
////////////////////////////////////////////////////////////////////////////
// rename stage top, joins alias table, free list and retirement map
// and holds the stall and grant logic
////////////////////////////////////////////////////////////////////////////
module rename_unit #(
	parameter int phys_regs = 64
) (
	input  logic                    clock,
	input  logic                    reset,
	input  rename_pkg::rename_req_t req [2],     // slot 0 is older
	input  rename_pkg::retire_t     retire [2],  // slot 0 is older
	input  logic                    flush,       // branch mispredict
	output rename_pkg::rename_rsp_t rsp [2],
	output logic                    stall        // hold req, group refused
);
	import rename_pkg::*;

	phys_idx_t  alloc_tag [2];            // from free list
	logic [1:0] avail;                    // free tags, capped at 2
	logic       need0;
	logic       need1;
	logic [1:0] need_count;               // tags the group asks for
	logic       grant;                    // group renames this cycle
	logic       take [2];                 // per-slot allocation
	retire_t    freed [2];                // overwritten committed tags
	phys_idx_t  commit_map [arch_regs];   // committed map for flush

	////////////////////////////////////////////////////////////////////////////
	// stall and grant
	////////////////////////////////////////////////////////////////////////////

	assign need0 = req[0].valid && req[0].has_dest;
	assign need1 = req[1].valid && req[1].has_dest;
	assign need_count = {1'b0, need0} + {1'b0, need1};

	assign stall = (need_count > avail) && !flush;  // whole group or nothing
	assign grant = !stall && !flush;

	assign take[0] = need0 && grant;
	assign take[1] = need1 && grant;

	////////////////////////////////////////////////////////////////////////////
	// blocks
	////////////////////////////////////////////////////////////////////////////

	rat u_rat (
		.clock      (clock),
		.reset      (reset),
		.req        (req),
		.alloc_tag  (alloc_tag),
		.grant      (grant),
		.flush      (flush),
		.commit_map (commit_map),
		.rsp        (rsp)
	);

	free_list #(
		.phys_regs (phys_regs)
	) u_free_list (
		.clock      (clock),
		.reset      (reset),
		.take       (take),
		.freed      (freed),
		.flush      (flush),
		.commit_map (commit_map),
		.alloc_tag  (alloc_tag),
		.avail      (avail)
	);

	rrat #(
		.phys_regs (phys_regs)
	) u_rrat (
		.clock      (clock),
		.reset      (reset),
		.retire     (retire),
		.commit_map (commit_map),
		.freed      (freed)
	);

endmodule

// ==== rename/free_list.sv ====
////////////////////////////////////////////////////////////////////////////
// free physical-tag vector, lowest-first two-tag allocation,
// retire frees and rebuild from the committed map on flush
////////////////////////////////////////////////////////////////////////////
module free_list #(
	parameter int phys_regs = 64
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  take [2],                            // slot uses a tag
	input  rename_pkg::retire_t   freed [2],                           // tags back from rrat
	input  logic                  flush,
	input  rename_pkg::phys_idx_t commit_map [rename_pkg::arch_regs],
	output rename_pkg::phys_idx_t alloc_tag [2],                       // lowest, next lowest
	output logic [1:0]            avail                                // free count, max 2
);
	import rename_pkg::*;

	logic [phys_regs-1:0] free_q;     // one bit per tag, set = free
	logic [phys_regs-1:0] free_d;
	logic [phys_regs-1:0] free_rest;  // free_q minus the first hit
	logic [phys_regs-1:0] held;       // tags named by the committed map
	logic                 hit0;       // at least one free
	logic                 hit1;       // at least two free
	logic [1:0]           n_take;     // tags leaving this edge

	// priority encoder, lowest set bit wins
	function automatic logic [phys_bits:0] first_set(input logic [phys_regs-1:0] vec);
		logic [phys_bits:0] res;
		res = '0;
		for (int i = phys_regs - 1; i >= 0; i--) begin
			if (vec[i]) begin
				res = {1'b1, phys_idx_t'(i)};
			end
		end
		return res;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// allocation
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		{hit0, alloc_tag[0]} = first_set(free_q);
		free_rest = free_q;
		free_rest[alloc_tag[0]] = 1'b0;  // no-op when nothing is free
		{hit1, alloc_tag[1]} = first_set(free_rest);
		avail = hit1 ? 2'd2 : (hit0 ? 2'd1 : 2'd0);
	end

	// slots take in order, so the count picks the tags
	assign n_take = {1'b0, take[0]} + {1'b0, take[1]};

	always_comb begin
		held = '0;
		for (int i = 0; i < arch_regs; i++) begin
			held[commit_map[i]] = 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// next vector
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		free_d = free_q;
		if (flush) begin
			free_d = ~held;  // everything not committed
		end else begin
			if (n_take != 2'd0) begin
				free_d[alloc_tag[0]] = 1'b0;
			end
			if (n_take == 2'd2) begin
				free_d[alloc_tag[1]] = 1'b0;
			end
			for (int k = 0; k < 2; k++) begin
				if (freed[k].valid) begin
					free_d[freed[k].tag] = 1'b1;  // old committed tag returns
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int t = 0; t < phys_regs; t++) begin
				free_q[t] <= (t >= arch_regs);  // low tags hold the identity map
			end
		end else begin
			free_q <= free_d;
		end
	end

endmodule

// ==== rename/rat.sv ====
////////////////////////////////////////////////////////////////////////////
// speculative register alias table, two-slot source lookup with
// intra-group bypass, destination update and flush restore
////////////////////////////////////////////////////////////////////////////
module rat (
	input  logic                    clock,
	input  logic                    reset,
	input  rename_pkg::rename_req_t req [2],                       // slot 0 is older
	input  rename_pkg::phys_idx_t   alloc_tag [2],                 // lowest free tags
	input  logic                    grant,                         // group accepted
	input  logic                    flush,                         // mispredict restore
	input  rename_pkg::phys_idx_t   commit_map [rename_pkg::arch_regs],
	output rename_pkg::rename_rsp_t rsp [2]
);
	import rename_pkg::*;

	phys_idx_t map_q [arch_regs];  // arch -> speculative phys tag

	logic      need0;     // slot 0 wants a new tag
	logic      need1;     // slot 1 wants a new tag
	phys_idx_t new_tag0;  // tag handed to slot 0
	phys_idx_t new_tag1;  // tag handed to slot 1
	logic      byp_a;     // slot 1 src a is slot 0 dest
	logic      byp_b;     // slot 1 src b is slot 0 dest

	// immediate beats bypass, bypass beats the table
	function automatic phys_idx_t pick_tag(
		input logic      imm,
		input logic      hit,
		input phys_idx_t byp,
		input phys_idx_t table_tag
	);
		phys_idx_t res;
		if (imm) begin
			res = '0;  // immediates carry tag zero
		end else if (hit) begin
			res = byp;
		end else begin
			res = table_tag;
		end
		return res;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// tag hand-out
	////////////////////////////////////////////////////////////////////////////

	assign need0 = req[0].valid && req[0].has_dest;
	assign need1 = req[1].valid && req[1].has_dest;

	assign new_tag0 = alloc_tag[0];
	assign new_tag1 = need0 ? alloc_tag[1] : alloc_tag[0];  // next free after slot 0

	// younger slot sees the older slot's rename
	assign byp_a = need0 && (req[1].opa == req[0].dest);
	assign byp_b = need0 && (req[1].opb == req[0].dest);

	////////////////////////////////////////////////////////////////////////////
	// lookup
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		// slot 0 reads the table as it stands
		rsp[0].valid    = req[0].valid && grant;
		rsp[0].dest_tag = need0 ? new_tag0 : '0;
		rsp[0].opa_tag  = pick_tag(req[0].opa_imm, 1'b0, '0, map_q[req[0].opa]);
		rsp[0].opb_tag  = pick_tag(req[0].opb_imm, 1'b0, '0, map_q[req[0].opb]);
		rsp[0].opa_imm  = req[0].opa_imm;
		rsp[0].opb_imm  = req[0].opb_imm;

		// slot 1 with bypass from slot 0
		rsp[1].valid    = req[1].valid && grant;
		rsp[1].dest_tag = need1 ? new_tag1 : '0;
		rsp[1].opa_tag  = pick_tag(req[1].opa_imm, byp_a, new_tag0, map_q[req[1].opa]);
		rsp[1].opb_tag  = pick_tag(req[1].opb_imm, byp_b, new_tag0, map_q[req[1].opb]);
		rsp[1].opa_imm  = req[1].opa_imm;
		rsp[1].opb_imm  = req[1].opb_imm;
	end

	////////////////////////////////////////////////////////////////////////////
	// table update
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < arch_regs; i++) begin
				map_q[i] <= phys_idx_t'(i);  // identity map
			end
		end else if (flush) begin
			map_q <= commit_map;  // drop all speculative renames
		end else if (grant) begin
			if (need0) begin
				map_q[req[0].dest] <= new_tag0;
			end
			if (need1) begin
				map_q[req[1].dest] <= new_tag1;  // last write wins on a shared dest
			end
		end
	end

endmodule

// ==== rename/rrat.sv ====
////////////////////////////////////////////////////////////////////////////
// retirement alias table, committed map and overwritten-tag report
////////////////////////////////////////////////////////////////////////////
module rrat #(
	parameter int phys_regs = 64
) (
	input  logic                  clock,
	input  logic                  reset,
	input  rename_pkg::retire_t   retire [2],                          // slot 0 is older
	output rename_pkg::phys_idx_t commit_map [rename_pkg::arch_regs],
	output rename_pkg::retire_t   freed [2]                            // tags to release
);
	import rename_pkg::*;

	phys_idx_t map_q [arch_regs];  // arch -> committed phys tag
	logic      same_dest;          // both retirements hit one register

	// the tag range must fit phys_bits and leave two spare tags
	if (phys_regs < arch_regs + 2 || phys_regs > (1 << phys_bits)) begin : g_bad_size
		$error("rrat: phys_regs outside the supported range");
	end

	assign commit_map = map_q;

	assign same_dest = retire[0].valid && retire[1].valid &&
		(retire[0].dest == retire[1].dest);

	////////////////////////////////////////////////////////////////////////////
	// overwritten tags
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		freed[0].valid = retire[0].valid;
		freed[0].dest  = retire[0].dest;
		freed[0].tag   = map_q[retire[0].dest];

		freed[1].valid = retire[1].valid;
		freed[1].dest  = retire[1].dest;
		// slot 1 overwrites what slot 0 just committed
		freed[1].tag   = same_dest ? retire[0].tag : map_q[retire[1].dest];
	end

	////////////////////////////////////////////////////////////////////////////
	// commit
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < arch_regs; i++) begin
				map_q[i] <= phys_idx_t'(i);  // identity map
			end
		end else begin
			if (retire[0].valid) begin
				map_q[retire[0].dest] <= retire[0].tag;
			end
			if (retire[1].valid) begin
				map_q[retire[1].dest] <= retire[1].tag;  // younger wins
			end
		end
	end

endmodule

// ==== rename_unit.f ====
common/rename_pkg.sv
rename/rat.sv
rename/free_list.sv
rename/rrat.sv
hdl/rename_unit.sv
tests/rename_unit_chk.sv
tests/rename_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the rename stage testbench with Verilator and run it
# the exit status is the simulator's, nonzero on any failure

verilator --binary --assert --timing \
	--top-module rename_unit_tb \
	-f rename_unit.f \
	-o rename_unit_sim \
	&& ./obj_dir/rename_unit_sim \
	|| exit 1

// ==== tests/rename_unit_chk.sv ====
////////////////////////////////////////////////////////////////////////////
// protocol assertions for the rename stage top, attached by bind
////////////////////////////////////////////////////////////////////////////
module rename_unit_chk (
	input logic                    clock,
	input logic                    reset,
	input rename_pkg::rename_req_t req [2],
	input rename_pkg::retire_t     retire [2],
	input logic                    flush,
	input rename_pkg::rename_rsp_t rsp [2],
	input logic                    stall
);
	import rename_pkg::*;

	logic retired_any;  // some retirement has been seen since reset

	always_ff @(posedge clock) begin
		if (reset) begin
			retired_any <= 1'b0;
		end else if (retire[0].valid || retire[1].valid) begin
			retired_any <= 1'b1;
		end
	end

	// a refused group shows nothing downstream
	a_no_valid_on_stall: assert property (@(posedge clock) disable iff (reset)
		stall |-> (!rsp[0].valid && !rsp[1].valid))
		else $error("response valid while stall is high");

	// reorder buffer keeps retirement out of a flush cycle
	a_no_retire_on_flush: assert property (@(posedge clock) disable iff (reset)
		flush |-> (!retire[0].valid && !retire[1].valid))
		else $error("retire valid in a flush cycle");

	// only the spare tags exist until something retires
	a_fresh_tag_slot0: assert property (@(posedge clock) disable iff (reset)
		(!retired_any && rsp[0].valid && req[0].has_dest) |->
		(rsp[0].dest_tag >= phys_idx_t'(arch_regs)))
		else $error("slot 0 got a low tag before any retirement");

	a_fresh_tag_slot1: assert property (@(posedge clock) disable iff (reset)
		(!retired_any && rsp[1].valid && req[1].has_dest) |->
		(rsp[1].dest_tag >= phys_idx_t'(arch_regs)))
		else $error("slot 1 got a low tag before any retirement");

endmodule

bind rename_unit rename_unit_chk u_chk (
	.clock  (clock),
	.reset  (reset),
	.req    (req),
	.retire (retire),
	.flush  (flush),
	.rsp    (rsp),
	.stall  (stall)
);

// ==== tests/rename_unit_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// rename stage testbench with directed groups and a seeded random run,
// checked every cycle against a reference model of the maps and free list
////////////////////////////////////////////////////////////////////////////
module rename_unit_tb;
	import rename_pkg::*;

	localparam int phys_regs     = 64;
	localparam int random_cycles = 2800;  // bulk of the run
	localparam int max_cycles    = 4000;  // directed plus random come to about 3000

	logic        clock = 1'b0;
	logic        reset;
	rename_req_t req [2];
	retire_t     retire [2];
	logic        flush;
	rename_rsp_t rsp [2];
	logic        stall;

	phys_idx_t            ref_map [arch_regs];   // speculative map
	phys_idx_t            ref_cmap [arch_regs];  // committed map
	logic [phys_regs-1:0] ref_free;              // set = free
	retire_t              pending [$];           // unretired renames in age order
	logic                 stalled_q = 1'b0;      // last cycle refused its group
	int                   cycles = 0;

	rename_unit #(
		.phys_regs (phys_regs)
	) u_dut (
		.clock  (clock),
		.reset  (reset),
		.req    (req),
		.retire (retire),
		.flush  (flush),
		.rsp    (rsp),
		.stall  (stall)
	);

	always #20 clock = ~clock;

	////////////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////////////

	task automatic reset_model();
		for (int i = 0; i < arch_regs; i++) begin
			ref_map[i]  = phys_idx_t'(i);
			ref_cmap[i] = phys_idx_t'(i);
		end
		for (int t = 0; t < phys_regs; t++) begin
			ref_free[t] = (t >= arch_regs);
		end
		pending.delete();
	endtask

	// expected responses and stall for the group on the inputs now
	function automatic void predict(
		input  rename_req_t r0,
		input  rename_req_t r1,
		input  logic        fl,
		output rename_rsp_t e0,
		output rename_rsp_t e1,
		output logic        est
	);
		int        found;
		int        n_need;
		phys_idx_t lo0;
		phys_idx_t lo1;
		logic      need0;
		logic      need1;
		logic      grant;
		found = 0;
		lo0 = '0;
		lo1 = '0;
		for (int t = 0; t < phys_regs; t++) begin
			if (ref_free[t]) begin
				if (found == 0) begin
					lo0 = phys_idx_t'(t);  // lowest free
				end else if (found == 1) begin
					lo1 = phys_idx_t'(t);  // second lowest
				end
				found++;
			end
		end
		need0 = r0.valid && r0.has_dest;
		need1 = r1.valid && r1.has_dest;
		n_need = 0;
		if (need0) n_need++;
		if (need1) n_need++;
		est   = (n_need > found) && !fl;
		grant = !est && !fl;

		e0.valid    = r0.valid && grant;
		e0.dest_tag = need0 ? lo0 : '0;
		e0.opa_tag  = r0.opa_imm ? '0 : ref_map[r0.opa];
		e0.opb_tag  = r0.opb_imm ? '0 : ref_map[r0.opb];
		e0.opa_imm  = r0.opa_imm;
		e0.opb_imm  = r0.opb_imm;

		e1.valid    = r1.valid && grant;
		e1.dest_tag = !need1 ? '0 : (need0 ? lo1 : lo0);
		e1.opa_tag  = r1.opa_imm ? '0 :
			((need0 && r1.opa == r0.dest) ? lo0 : ref_map[r1.opa]);
		e1.opb_tag  = r1.opb_imm ? '0 :
			((need0 && r1.opb == r0.dest) ? lo0 : ref_map[r1.opb]);
		e1.opa_imm  = r1.opa_imm;
		e1.opb_imm  = r1.opb_imm;
	endfunction

	// model state after the coming edge
	task automatic advance_model(
		input rename_req_t r0,
		input rename_req_t r1,
		input rename_rsp_t e0,
		input rename_rsp_t e1,
		input logic        fl
	);
		if (fl) begin
			ref_map  = ref_cmap;
			ref_free = '1;
			for (int i = 0; i < arch_regs; i++) begin
				ref_free[ref_cmap[i]] = 1'b0;  // committed tags stay busy
			end
		end else begin
			if (e0.valid && r0.has_dest) begin
				ref_map[r0.dest]      = e0.dest_tag;
				ref_free[e0.dest_tag] = 1'b0;
				pending.push_back({1'b1, r0.dest, e0.dest_tag});
			end
			if (e1.valid && r1.has_dest) begin
				ref_map[r1.dest]      = e1.dest_tag;  // written after slot 0 and wins
				ref_free[e1.dest_tag] = 1'b0;
				pending.push_back({1'b1, r1.dest, e1.dest_tag});
			end
			for (int k = 0; k < 2; k++) begin
				if (retire[k].valid) begin
					ref_free[ref_cmap[retire[k].dest]] = 1'b1;  // old committed tag back
					ref_cmap[retire[k].dest] = retire[k].tag;
				end
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// compare
	////////////////////////////////////////////////////////////////////////////

	task automatic fail_value(input string msg);
		$display("FAILED %0t: %s", $time, msg);
		$display("sim failed");
		$fatal(1, "rename result mismatch");
	endtask

	task automatic check_slot(input int k, input rename_rsp_t got, input rename_rsp_t want);
		assert (got.valid == want.valid)
			else fail_value($sformatf("slot %0d valid %0b, expected %0b",
				k, got.valid, want.valid));
		if (want.valid) begin
			assert (got.dest_tag == want.dest_tag)
				else fail_value($sformatf("slot %0d dest_tag %0d, expected %0d",
					k, got.dest_tag, want.dest_tag));
			assert (got.opa_tag == want.opa_tag)
				else fail_value($sformatf("slot %0d opa_tag %0d, expected %0d",
					k, got.opa_tag, want.opa_tag));
			assert (got.opb_tag == want.opb_tag)
				else fail_value($sformatf("slot %0d opb_tag %0d, expected %0d",
					k, got.opb_tag, want.opb_tag));
			assert (got.opa_imm == want.opa_imm && got.opb_imm == want.opb_imm)
				else fail_value($sformatf("slot %0d immediate flags wrong", k));
		end
	endtask

	always @(negedge clock) begin : compare
		rename_rsp_t e0;
		rename_rsp_t e1;
		logic        est;
		if (reset) begin
			reset_model();
			stalled_q = 1'b0;
		end else begin
			predict(req[0], req[1], flush, e0, e1, est);
			assert (stall == est)
				else fail_value($sformatf("stall %0b, expected %0b", stall, est));
			check_slot(0, rsp[0], e0);
			check_slot(1, rsp[1], e1);
			stalled_q = est;
			advance_model(req[0], req[1], e0, e1, flush);
		end
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("timeout, the tests did not finish within %0d cycles", max_cycles);
			$display("sim failed");
			$fatal(1, "timeout");
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////

	function automatic rename_req_t make_req(
		input logic has_dest,
		input int   dest,
		input int   opa,
		input int   opb,
		input logic opb_imm
	);
		rename_req_t r;
		r.valid    = 1'b1;
		r.has_dest = has_dest;
		r.dest     = arch_idx_t'(dest);
		r.opa      = arch_idx_t'(opa);
		r.opb      = arch_idx_t'(opb);
		r.opa_imm  = 1'b0;
		r.opb_imm  = opb_imm;
		return r;
	endfunction

	function automatic rename_req_t random_req();
		rename_req_t r;
		r.valid    = ($urandom % 8) != 0;
		r.has_dest = ($urandom % 4) != 0;
		r.dest     = arch_idx_t'($urandom % arch_regs);
		r.opa      = arch_idx_t'($urandom % arch_regs);
		r.opb      = arch_idx_t'($urandom % arch_regs);
		r.opa_imm  = ($urandom % 8) == 0;
		r.opb_imm  = ($urandom % 8) == 0;
		return r;
	endfunction

	// one cycle of inputs where a refused group stays on req
	task automatic drive_cycle(
		input rename_req_t r0,
		input rename_req_t r1,
		input int          n_ret,
		input logic        fl
	);
		retire_t ret0;
		retire_t ret1;
		ret0 = '0;
		ret1 = '0;
		@(posedge clock);
		if (fl) begin
			pending.delete();  // younger renames squashed
		end else begin
			if (n_ret > 0 && pending.size() > 0) ret0 = pending.pop_front();
			if (n_ret > 1 && pending.size() > 0) ret1 = pending.pop_front();
		end
		if (!stalled_q) begin
			req[0] <= r0;
			req[1] <= r1;
		end
		retire[0] <= ret0;
		retire[1] <= ret1;
		flush     <= fl;
	endtask

	initial begin
		int   n_ret;
		logic fl;
		void'($urandom(6));
		reset     <= 1'b1;
		flush     <= 1'b0;
		req[0]    <= '0;
		req[1]    <= '0;
		retire[0] <= '0;
		retire[1] <= '0;
		repeat (2) @(posedge clock);
		reset <= 1'b0;

		// identity reads followed by the first two spare tags
		for (int g = 0; g < 8; g++) begin
			drive_cycle(make_req(0, 0, 4*g, 4*g+1, 0),
				make_req(0, 0, 4*g+2, 4*g+3, 0), 0, 0);
		end
		drive_cycle(make_req(1, 5, 1, 2, 0), make_req(1, 6, 3, 4, 0), 0, 0);
		@(negedge clock);
		assert (rsp[0].dest_tag == phys_idx_t'(arch_regs) &&
			rsp[1].dest_tag == phys_idx_t'(arch_regs + 1))
			else fail_value("first destinations did not get the lowest spare tags");

		// bypass, immediate and shared dest
		drive_cycle(make_req(1, 7, 1, 2, 0), make_req(1, 8, 7, 7, 1), 0, 0);
		drive_cycle(make_req(1, 9, 7, 8, 0), make_req(1, 9, 9, 7, 0), 0, 0);
		drive_cycle(make_req(0, 0, 9, 9, 0), '0, 0, 0);

		// drain the free list and hold the group until two tags come back
		while (!stalled_q) begin
			drive_cycle(make_req(1, 10, 9, 10, 0), make_req(1, 11, 10, 11, 0), 0, 0);
		end
		repeat (3) drive_cycle('0, '0, 0, 0);
		drive_cycle('0, '0, 2, 0);
		drive_cycle('0, '0, 0, 0);
		@(negedge clock);
		assert (!stall && rsp[0].valid)
			else fail_value("held group still refused after retirement freed tags");

		// reg 7 retires and its reset tag comes back first
		drive_cycle('0, '0, 1, 0);
		drive_cycle(make_req(1, 12, 1, 2, 0), '0, 0, 0);
		@(negedge clock);
		assert (rsp[0].dest_tag == phys_idx_t'(7))
			else fail_value("freed committed tag was not the next allocation");
		while (pending.size() > 0) begin
			drive_cycle('0, '0, 2, 0);
		end

		// flush restore
		drive_cycle(make_req(1, 3, 1, 2, 0), make_req(1, 4, 3, 3, 0), 0, 0);
		drive_cycle(make_req(1, 3, 4, 4, 0), '0, 1, 0);
		drive_cycle('0, '0, 0, 1);
		drive_cycle(make_req(1, 13, 3, 4, 0), make_req(1, 14, 13, 3, 0), 0, 0);
		drive_cycle('0, '0, 2, 0);

		// long random mix where the retire rate alternates to force stalls
		for (int i = 0; i < random_cycles; i++) begin
			if (((i / 200) % 2) == 1) begin
				n_ret = int'($urandom % 3);
			end else begin
				n_ret = ($urandom % 6 == 0) ? 1 : 0;
			end
			fl = ($urandom % 96) == 0;
			drive_cycle(random_req(), random_req(), n_ret, fl);
		end
		repeat (2) drive_cycle('0, '0, 0, 0);
		@(posedge clock);

		$display("sim passed");
		$finish;
	end

endmodule
